/* hdl/csr_arch_pkg.sv */
/* Machine-mode CSR map, CSR op codes and trap causes for RV32.
   Only the machine CSRs of the execute stage are listed; minstreth is absent */
`default_nettype none

package csr_arch_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [1:0]  csr_op_t;
  typedef logic [3:0]  cause_t;

  typedef enum logic [2:0] {
    CSR,
    ECALL,
    EBREAK,
    MRET,
    ILLEGAL
  } sys_kind_e;

  // ==================================================
  // Encoding of the SYSTEM opcode space
  localparam logic [6:0]  OPCODE_SYSTEM  = 7'b111_0011;
  localparam logic [11:0] FUNCT12_ECALL  = 12'h000;
  localparam logic [11:0] FUNCT12_EBREAK = 12'h001;
  localparam logic [11:0] FUNCT12_MRET   = 12'h302;

  // ==================================================
  // Machine CSR addresses
  localparam csr_addr_t MSTATUS  = 12'h300;
  localparam csr_addr_t MIE      = 12'h304;
  localparam csr_addr_t MTVEC    = 12'h305;
  localparam csr_addr_t MSCRATCH = 12'h340;
  localparam csr_addr_t MEPC     = 12'h341;
  localparam csr_addr_t MCAUSE   = 12'h342;
  localparam csr_addr_t MTVAL    = 12'h343;
  localparam csr_addr_t MIP      = 12'h344;
  localparam csr_addr_t MINSTRET = 12'hB02;

  // funct3[1:0] of the CSR forms
  localparam csr_op_t CSR_RW = 2'b01;
  localparam csr_op_t CSR_RS = 2'b10;
  localparam csr_op_t CSR_RC = 2'b11;

  // Exception codes
  localparam cause_t ILLEGAL_INSTR = 4'd2;
  localparam cause_t BREAKPOINT    = 4'd3;
  localparam cause_t ECALL_MACHINE = 4'd11;

  // Field positions in mstatus, mie and mip
  localparam int MIE_BIT  = 3;
  localparam int MPIE_BIT = 7;
  localparam int MPP_LO   = 11;
  localparam int MSIE_BIT = 3;
  localparam int MTIE_BIT = 7;
  localparam int MEIE_BIT = 11;

endpackage

`default_nettype wire

/* hdl/csr_pipe_pkg.sv */
/* Types that move between the decode, queue and CSR stages.
   sys_op_t carries an operation that is already fully classified */
`default_nettype none

package csr_pipe_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_sel_t;

  // Depth of the decoded-op queue
  localparam int QUEUE_DEPTH = 2;

  // Instruction as it arrives from fetch
  typedef struct packed {
    word_t ir;
    word_t pc;
    word_t op1;
  } sys_instr_t;

  // Register file write-back
  typedef struct packed {
    reg_sel_t sel;
    word_t    data;
  } regwr_t;

  // One decoded system operation
  typedef struct packed {
    csr_arch_pkg::sys_kind_e kind;
    csr_arch_pkg::csr_addr_t csr_addr;
    csr_arch_pkg::csr_op_t   csr_op;
    // zimm or op1, already selected
    word_t                   src;
    reg_sel_t                rd;
    logic                    wb;
    word_t                   pc;
    word_t                   tval;
    csr_arch_pkg::cause_t    cause;
  } sys_op_t;

endpackage

`default_nettype wire

/* hdl/sys_decode.sv */
/* Classifies one SYSTEM instruction per cycle into a machine-mode op.
   instr must stay stable while instr_vld is high and instr_rdy is low */
`default_nettype none

module sys_decode (
  input  logic                    clk,
  input  logic                    reset,
  input  csr_pipe_pkg::sys_instr_t instr,
  input  logic                    instr_vld,
  output logic                    instr_rdy,
  output csr_pipe_pkg::sys_op_t   dec_op,
  output logic                    dec_vld,
  input  logic                    dec_rdy
);
  import csr_arch_pkg::*;
  import csr_pipe_pkg::*;

  word_t       ir;
  logic [2:0]  funct3;
  logic [11:0] funct12;
  reg_sel_t    rd;
  reg_sel_t    rs1;
  sys_op_t     op_next;
  logic        accept;

  function automatic logic csr_known(input csr_addr_t addr);
    case (addr)
      MSTATUS, MIE, MTVEC, MSCRATCH, MEPC, MCAUSE, MTVAL, MIP, MINSTRET: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  assign ir      = instr.ir;
  assign funct3  = ir[14:12];
  assign funct12 = ir[31:20];
  assign rd      = ir[11:7];
  assign rs1     = ir[19:15];

  // ==================================================
  // Classification
  always_comb begin
    op_next.csr_addr = funct12;
    op_next.csr_op   = funct3[1:0];
    op_next.src      = funct3[2] ? {27'b0, rs1} : instr.op1;
    op_next.rd       = rd;
    op_next.wb       = (rd != '0);
    op_next.pc       = instr.pc;
    // Anything not matched below traps as illegal
    op_next.kind     = ILLEGAL;
    op_next.tval     = ir;
    op_next.cause    = ILLEGAL_INSTR;

    if (ir[6:0] == OPCODE_SYSTEM) begin
      if (funct3 == 3'b000) begin
        case (funct12)
          FUNCT12_ECALL: begin
            op_next.kind  = ECALL;
            op_next.tval  = '0;
            op_next.cause = ECALL_MACHINE;
          end
          FUNCT12_EBREAK: begin
            op_next.kind  = EBREAK;
            op_next.tval  = instr.pc;
            op_next.cause = BREAKPOINT;
          end
          FUNCT12_MRET: begin
            op_next.kind  = MRET;
            op_next.tval  = '0;
            op_next.cause = '0;
          end
          default: begin
          end
        endcase
      end else if (funct3[1:0] != 2'b00 && csr_known(funct12)) begin
        op_next.kind  = CSR;
        op_next.tval  = '0;
        op_next.cause = '0;
      end
    end
  end

  // ==================================================
  // One-entry output register
  assign instr_rdy = !dec_vld || dec_rdy;
  assign accept    = instr_vld && instr_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_vld <= 1'b0;
    end else if (accept) begin
      dec_vld <= 1'b1;
    end else if (dec_rdy) begin
      dec_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec_op <= op_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/sys_queue.sv */
/* Two-entry FWFT queue of decoded ops; an empty queue adds one cycle.
   A push into a full queue is taken when the head pops in the same cycle */
`default_nettype none

module sys_queue (
  input  logic                  clk,
  input  logic                  reset,
  input  csr_pipe_pkg::sys_op_t dec_op,
  input  logic                  dec_vld,
  output logic                  dec_rdy,
  output csr_pipe_pkg::sys_op_t q_op,
  output logic                  q_vld,
  input  logic                  q_rdy
);
  import csr_pipe_pkg::*;

  sys_op_t    mem [QUEUE_DEPTH];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  assign q_vld   = (count != 2'd0);
  assign q_op    = mem[rd_ptr];
  // Free entry, or the head leaves this cycle
  assign dec_rdy = (count != 2'(QUEUE_DEPTH)) || q_rdy;

  assign push = dec_vld && dec_rdy;
  assign pop  = q_vld && q_rdy;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= dec_op;
    end
  end

  // Single-bit pointers wrap on their own at depth 2
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/csr_file.sv */
/* Machine CSR file with trap entry and MRET; interrupts are never taken.
   mip only mirrors the irq levels, and minstret counts every completed op */
`default_nettype none

module csr_file (
  input  logic                  clk,
  input  logic                  reset,
  input  csr_pipe_pkg::sys_op_t q_op,
  input  logic                  q_vld,
  output logic                  q_rdy,
  input  logic                  software_irq,
  input  logic                  timer_irq,
  input  logic                  external_irq,
  output csr_pipe_pkg::regwr_t  regwr,
  output logic                  regwr_en,
  output csr_pipe_pkg::word_t   branch_target,
  output logic                  branch
);
  import csr_arch_pkg::*;
  import csr_pipe_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    TRAP,
    JUMP
  } seq_state_e;

  seq_state_e state;

  logic  mstatus_mie;
  logic  mstatus_mpie;
  logic  mie_msie;
  logic  mie_mtie;
  logic  mie_meie;
  logic  mip_msip;
  logic  mip_mtip;
  logic  mip_meip;
  word_t mtvec;
  word_t mepc;
  word_t mscratch;
  word_t mcause;
  word_t mtval;
  word_t minstret;

  word_t rdata;
  word_t wdata;
  logic  accept;
  logic  is_csr;
  logic  is_trap;
  logic  is_mret;
  logic  ret_op;

  assign q_rdy   = (state == IDLE);
  assign accept  = q_vld && q_rdy;
  assign is_csr  = (q_op.kind == CSR);
  assign is_mret = (q_op.kind == MRET);
  assign is_trap = (q_op.kind == ECALL) || (q_op.kind == EBREAK) || (q_op.kind == ILLEGAL);
  assign branch  = (state == JUMP);

  // ==================================================
  // Masked read view and read-modify-write value
  always_comb begin
    rdata = '0;
    case (q_op.csr_addr)
      MSTATUS: begin
        rdata[MIE_BIT]     = mstatus_mie;
        rdata[MPIE_BIT]    = mstatus_mpie;
        rdata[MPP_LO +: 2] = 2'b11;
      end
      MIE: begin
        rdata[MSIE_BIT] = mie_msie;
        rdata[MTIE_BIT] = mie_mtie;
        rdata[MEIE_BIT] = mie_meie;
      end
      MTVEC:    rdata = mtvec;
      MSCRATCH: rdata = mscratch;
      MEPC:     rdata = mepc;
      MCAUSE:   rdata = mcause;
      MTVAL:    rdata = mtval;
      MIP: begin
        rdata[MSIE_BIT] = mip_msip;
        rdata[MTIE_BIT] = mip_mtip;
        rdata[MEIE_BIT] = mip_meip;
      end
      // Count before the current op retires
      MINSTRET: rdata = minstret;
      default:  rdata = '0;
    endcase
  end

  always_comb begin
    case (q_op.csr_op)
      CSR_RW:  wdata = q_op.src;
      CSR_RS:  wdata = rdata | q_op.src;
      CSR_RC:  wdata = rdata & ~q_op.src;
      default: wdata = rdata;
    endcase
  end

  // ==================================================
  // CSR registers
  always_ff @(posedge clk) begin
    if (reset) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
      mie_msie     <= 1'b0;
      mie_mtie     <= 1'b0;
      mie_meie     <= 1'b0;
      mip_msip     <= 1'b0;
      mip_mtip     <= 1'b0;
      mip_meip     <= 1'b0;
      mtvec        <= '0;
      mepc         <= '0;
      mscratch     <= '0;
      mcause       <= '0;
      mtval        <= '0;
      minstret     <= '0;
    end else begin
      mip_msip <= software_irq;
      mip_mtip <= timer_irq;
      mip_meip <= external_irq;

      if (accept && is_csr) begin
        case (q_op.csr_addr)
          MSTATUS: begin
            mstatus_mie  <= wdata[MIE_BIT];
            mstatus_mpie <= wdata[MPIE_BIT];
          end
          MIE: begin
            mie_msie <= wdata[MSIE_BIT];
            mie_mtie <= wdata[MTIE_BIT];
            mie_meie <= wdata[MEIE_BIT];
          end
          MTVEC:    mtvec    <= {wdata[31:2], 2'b00};
          MSCRATCH: mscratch <= wdata;
          MEPC:     mepc     <= {wdata[31:2], 2'b00};
          MCAUSE:   mcause   <= wdata;
          MTVAL:    mtval    <= wdata;
          // mip and minstret are read-only here
          default: begin
          end
        endcase
      end else if (accept && is_trap) begin
        mepc         <= {q_op.pc[31:2], 2'b00};
        mcause       <= {28'b0, q_op.cause};
        mtval        <= q_op.tval;
        mstatus_mpie <= mstatus_mie;
        mstatus_mie  <= 1'b0;
      end else if (accept && is_mret) begin
        mstatus_mie  <= mstatus_mpie;
        mstatus_mpie <= 1'b1;
      end

      // CSR ops retire on accept, traps and MRET on leaving TRAP
      if ((accept && is_csr) || state == TRAP) begin
        minstret <= minstret + 32'd1;
      end
    end
  end

  // ==================================================
  // Trap and return sequencer
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (accept && !is_csr) begin
            state <= TRAP;
          end
        end
        TRAP:    state <= JUMP;
        JUMP:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ret_op <= is_mret;
    end
    if (state == TRAP) begin
      branch_target <= ret_op ? mepc : mtvec;
    end
  end

  // Write-back strobe, only for CSR ops with a nonzero rd
  always_ff @(posedge clk) begin
    if (reset) begin
      regwr_en <= 1'b0;
    end else begin
      regwr_en <= accept && is_csr && q_op.wb;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      regwr.sel  <= q_op.rd;
      regwr.data <= rdata;
    end
  end

endmodule

`default_nettype wire

/* hdl/csr_exec_top.sv */
/* SYSTEM-instruction execute path: decode, op queue, machine CSR file.
   Result latency varies; regwr_en or branch marks the end of each op */
`default_nettype none

module csr_exec_top (
  input  logic                     clk,
  input  logic                     reset,
  input  csr_pipe_pkg::sys_instr_t instr,
  input  logic                     instr_vld,
  output logic                     instr_rdy,
  input  logic                     software_irq,
  input  logic                     timer_irq,
  input  logic                     external_irq,
  output csr_pipe_pkg::regwr_t     regwr,
  output logic                     regwr_en,
  output csr_pipe_pkg::word_t      branch_target,
  output logic                     branch
);
  import csr_pipe_pkg::*;

  sys_op_t dec_op;
  logic    dec_vld;
  logic    dec_rdy;
  sys_op_t q_op;
  logic    q_vld;
  logic    q_rdy;

  sys_decode i_sys_decode (
    .clk       (clk),
    .reset     (reset),
    .instr     (instr),
    .instr_vld (instr_vld),
    .instr_rdy (instr_rdy),
    .dec_op    (dec_op),
    .dec_vld   (dec_vld),
    .dec_rdy   (dec_rdy)
  );

  sys_queue i_sys_queue (
    .clk     (clk),
    .reset   (reset),
    .dec_op  (dec_op),
    .dec_vld (dec_vld),
    .dec_rdy (dec_rdy),
    .q_op    (q_op),
    .q_vld   (q_vld),
    .q_rdy   (q_rdy)
  );

  csr_file i_csr_file (
    .clk           (clk),
    .reset         (reset),
    .q_op          (q_op),
    .q_vld         (q_vld),
    .q_rdy         (q_rdy),
    .software_irq  (software_irq),
    .timer_irq     (timer_irq),
    .external_irq  (external_irq),
    .regwr         (regwr),
    .regwr_en      (regwr_en),
    .branch_target (branch_target),
    .branch        (branch)
  );

endmodule

`default_nettype wire

/* bench/csr_exec_checker.sv */
/* Concurrent assertions on csr_file outputs, sampled at the rising edge.
   All properties are disabled while reset is high */
`default_nettype none

module csr_exec_checker (
  input logic                 clk,
  input logic                 reset,
  input csr_pipe_pkg::regwr_t regwr,
  input logic                 regwr_en,
  input csr_pipe_pkg::word_t  branch_target,
  input logic                 branch,
  input logic                 q_rdy,
  input logic                 trap_start
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  sel_nonzero: assert property (@(posedge clk) disable iff (reset)
    regwr_en |-> regwr.sel != 5'd0)
    else begin
      fail_count++;
      $error("regwr_en high with register index zero");
    end

  one_result: assert property (@(posedge clk) disable iff (reset)
    !(regwr_en && branch))
    else begin
      fail_count++;
      $error("regwr_en and branch high together");
    end

  target_aligned: assert property (@(posedge clk) disable iff (reset)
    branch |-> branch_target[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("branch_target not word aligned");
    end

  // TRAP and JUMP each hold off the queue for one cycle
  busy_stalls: assert property (@(posedge clk) disable iff (reset)
    trap_start |=> !q_rdy [*2] ##1 q_rdy)
    else begin
      fail_count++;
      $error("q_rdy wrong during a trap or MRET sequence");
    end

endmodule

bind csr_file csr_exec_checker i_csr_exec_checker (
  .clk           (clk),
  .reset         (reset),
  .regwr         (regwr),
  .regwr_en      (regwr_en),
  .branch_target (branch_target),
  .branch        (branch),
  .q_rdy         (q_rdy),
  .trap_start    (q_vld && q_rdy && q_op.kind != csr_arch_pkg::CSR)
);

`default_nettype wire

/* bench/csr_exec_model.svh */
/* Machine CSR model with minstret and the queue of expected results.
   Included inside csr_exec_tb; reads the irq levels driven there */
`ifndef CSR_EXEC_MODEL_SVH
`define CSR_EXEC_MODEL_SVH

typedef struct packed {
  logic   is_branch;
  regwr_t wr;
  word_t  target;
} expect_t;

expect_t expected[$];

logic  st_mie;
logic  st_mpie;
word_t mie_reg;
word_t mtvec_reg;
word_t mepc_reg;
word_t mscratch_reg;
word_t mcause_reg;
word_t mtval_reg;
int    retired;

task automatic reset_model();
  st_mie       = 1'b0;
  st_mpie      = 1'b0;
  mie_reg      = '0;
  mtvec_reg    = '0;
  mepc_reg     = '0;
  mscratch_reg = '0;
  mcause_reg   = '0;
  mtval_reg    = '0;
  retired      = 0;
  expected.delete();
endtask

function automatic logic supported_csr(input csr_addr_t addr);
  return addr inside {12'h300, 12'h304, 12'h305, 12'h340, 12'h341,
                      12'h342, 12'h343, 12'h344, 12'hB02};
endfunction

// Value as software sees it
function automatic word_t masked_read(input csr_addr_t addr);
  word_t v;
  v = '0;
  case (addr)
    12'h300: begin
      v       = 32'h0000_1800;
      v[3]    = st_mie;
      v[7]    = st_mpie;
    end
    12'h304: v = mie_reg;
    12'h305: v = mtvec_reg;
    12'h340: v = mscratch_reg;
    12'h341: v = mepc_reg;
    12'h342: v = mcause_reg;
    12'h343: v = mtval_reg;
    12'h344: v = {20'b0, external_irq, 3'b0, timer_irq, 3'b0, software_irq, 3'b0};
    12'hB02: v = word_t'(retired);
    default: v = '0;
  endcase
  return v;
endfunction

task automatic field_write(input csr_addr_t addr, input word_t v);
  case (addr)
    12'h300: begin
      st_mie  = v[3];
      st_mpie = v[7];
    end
    12'h304: mie_reg      = v & 32'h0000_0888;
    12'h305: mtvec_reg    = v & ~32'h3;
    12'h340: mscratch_reg = v;
    12'h341: mepc_reg     = v & ~32'h3;
    12'h342: mcause_reg   = v;
    12'h343: mtval_reg    = v;
    // mip and minstret ignore writes
    default: begin
    end
  endcase
endtask

task automatic take_trap(input word_t pc, input logic [3:0] cause, input word_t tval);
  expected.push_back('{is_branch: 1'b1, wr: '0, target: mtvec_reg});
  mepc_reg   = pc & ~32'h3;
  mcause_reg = {28'b0, cause};
  mtval_reg  = tval;
  st_mpie    = st_mie;
  st_mie     = 1'b0;
endtask

// One accepted instruction, in program order
task automatic predict(input sys_instr_t in);
  word_t      ir;
  logic [2:0] f3;
  csr_addr_t  addr;
  reg_sel_t   rd;
  logic       sys;
  word_t      old;
  word_t      src;
  ir   = in.ir;
  f3   = ir[14:12];
  addr = ir[31:20];
  rd   = ir[11:7];
  sys  = (ir[6:0] == 7'b111_0011);
  if (sys && f3 == 3'b000 && addr == 12'h000) begin
    take_trap(in.pc, 4'd11, '0);
  end else if (sys && f3 == 3'b000 && addr == 12'h001) begin
    take_trap(in.pc, 4'd3, in.pc);
  end else if (sys && f3 == 3'b000 && addr == 12'h302) begin
    expected.push_back('{is_branch: 1'b1, wr: '0, target: mepc_reg});
    st_mie  = st_mpie;
    st_mpie = 1'b1;
  end else if (sys && f3[1:0] != 2'b00 && supported_csr(addr)) begin
    old = masked_read(addr);
    src = f3[2] ? {27'b0, ir[19:15]} : in.op1;
    case (f3[1:0])
      2'b01:   field_write(addr, src);
      2'b10:   field_write(addr, old | src);
      default: field_write(addr, old & ~src);
    endcase
    if (rd != 5'd0) begin
      expected.push_back('{is_branch: 1'b0, wr: '{sel: rd, data: old}, target: '0});
    end
  end else begin
    take_trap(in.pc, 4'd2, ir);
  end
  retired++;
endtask

`endif

/* bench/csr_exec_tb.sv */
/* Random SYSTEM-instruction testbench for csr_exec_top with a CSR model.
   irq levels only change while the pipeline is drained */
`default_nettype none

module csr_exec_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import csr_arch_pkg::*;
  import csr_pipe_pkg::*;

  localparam int HANDSHAKE_LIMIT = 100;
  localparam int DRAIN_LIMIT     = 400;

  logic       clk;
  logic       reset;
  sys_instr_t instr;
  logic       instr_vld;
  logic       instr_rdy;
  logic       software_irq;
  logic       timer_irq;
  logic       external_irq;
  regwr_t     regwr;
  logic       regwr_en;
  word_t      branch_target;
  logic       branch;

  integer    seed = 32'h35eb_5386;
  csr_addr_t csr_list [9] = '{MSTATUS, MIE, MTVEC, MSCRATCH, MEPC,
                              MCAUSE, MTVAL, MIP, MINSTRET};

  `include "csr_exec_model.svh"

  csr_exec_top i_csr_exec_top (
    .clk           (clk),
    .reset         (reset),
    .instr         (instr),
    .instr_vld     (instr_vld),
    .instr_rdy     (instr_rdy),
    .software_irq  (software_irq),
    .timer_irq     (timer_irq),
    .external_irq  (external_irq),
    .regwr         (regwr),
    .regwr_en      (regwr_en),
    .branch_target (branch_target),
    .branch        (branch)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==================================================
  // Reporting and compare tasks
  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_regwr(input regwr_t got, input regwr_t want);
    if (got !== want) begin
      stop_with_error($sformatf("[FAIL] t=%0t regwr: got sel=%0d data=%08h, expected sel=%0d data=%08h",
                                $time, got.sel, got.data, want.sel, want.data));
    end
  endtask

  task automatic check_branch(input word_t got, input word_t want);
    if (got !== want) begin
      stop_with_error($sformatf("[FAIL] t=%0t branch_target: got %08h, expected %08h",
                                $time, got, want));
    end
  endtask

  always @(negedge clk) begin : output_monitor
    expect_t want;
    if (!reset) begin
      if (i_csr_exec_top.i_csr_file.i_csr_exec_checker.fail_count != 0) begin
        stop_with_error("An assertion in the bound checker failed");
      end
      if (regwr_en || branch) begin
        if (expected.size() == 0) begin
          stop_with_error("Output pulse seen while no result was expected");
        end else begin
          want = expected.pop_front();
          if (regwr_en && branch) begin
            stop_with_error("regwr_en and branch pulsed in the same cycle");
          end else if (want.is_branch && !branch) begin
            stop_with_error("regwr_en pulsed where a branch was expected");
          end else if (!want.is_branch && !regwr_en) begin
            stop_with_error("branch pulsed where a register write was expected");
          end else if (want.is_branch) begin
            check_branch(branch_target, want.target);
          end else begin
            check_regwr(regwr, want.wr);
          end
        end
      end
    end
  end

  // ==================================================
  // Stimulus helpers, entered 2 ns after a rising edge
  function automatic word_t encode_csr(input csr_addr_t addr, input logic [2:0] f3,
                                       input reg_sel_t rs1, input reg_sel_t rd);
    return {addr, rs1, f3, rd, OPCODE_SYSTEM};
  endfunction

  function automatic word_t encode_system(input logic [11:0] funct12);
    return {funct12, 5'd0, 3'b000, 5'd0, OPCODE_SYSTEM};
  endfunction

  function automatic word_t random_pc();
    return word_t'($random(seed)) & ~32'h3;
  endfunction

  task automatic issue(input word_t ir, input word_t pc, input word_t op1);
    int waited;
    waited    = 0;
    instr.ir  = ir;
    instr.pc  = pc;
    instr.op1 = op1;
    instr_vld = 1'b1;
    @(negedge clk);
    while (!instr_rdy) begin
      waited++;
      if (waited > HANDSHAKE_LIMIT) begin
        stop_with_error("Timeout waiting for instr_rdy");
      end
      @(negedge clk);
    end
    // Transfer happens at the coming edge
    predict(instr);
    @(posedge clk);
    #2;
  endtask

  task automatic idle(input int cycles);
    instr_vld = 1'b0;
    repeat (cycles) @(posedge clk);
    #2;
  endtask

  task automatic drain();
    int waited;
    waited    = 0;
    instr_vld = 1'b0;
    while (expected.size() != 0) begin
      waited++;
      if (waited > DRAIN_LIMIT) begin
        stop_with_error("Timeout waiting for the expected results");
      end
      @(posedge clk);
    end
    repeat (6) @(posedge clk);
    #2;
  endtask

  task automatic random_csr_op(input csr_addr_t addr);
    logic [2:0] f3;
    f3 = 3'($random(seed));
    if (f3[1:0] == 2'b00) begin
      f3[1:0] = 2'b01;
    end
    issue(encode_csr(addr, f3, 5'($random(seed)), 5'($random(seed))),
          random_pc(), word_t'($random(seed)));
  endtask

  // CSRRSI with zimm zero reads without writing
  task automatic read_back(input csr_addr_t addr);
    reg_sel_t rd;
    rd = reg_sel_t'(1 + $unsigned($random(seed)) % 31);
    issue(encode_csr(addr, 3'b110, 5'd0, rd), random_pc(), '0);
  endtask

  // ==================================================
  // Test sequence
  initial begin
    word_t bad;
    int    pick;
    instr        = '0;
    instr_vld    = 1'b0;
    software_irq = 1'b0;
    timer_irq    = 1'b0;
    external_irq = 1'b0;
    reset        = 1'b1;
    reset_model();
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;

    // Random CSR traffic with gaps
    for (int i = 0; i < 300; i++) begin
      random_csr_op(csr_list[$unsigned($random(seed)) % 9]);
      if ($unsigned($random(seed)) % 4 == 0) begin
        idle(1 + $unsigned($random(seed)) % 3);
      end
    end
    for (int i = 0; i < 9; i++) begin
      read_back(csr_list[i]);
    end
    drain();

    // ECALL and EBREAK, then MRET on every other pass
    for (int i = 0; i < 24; i++) begin
      issue(encode_csr(MTVEC, 3'b001, 5'd0, 5'd0), random_pc(), word_t'($random(seed)));
      issue(encode_csr(MSTATUS, 3'b001, 5'd0, 5'd0), random_pc(), word_t'($random(seed)));
      issue(encode_system(i % 3 == 0 ? FUNCT12_EBREAK : FUNCT12_ECALL), random_pc(), '0);
      read_back(MEPC);
      read_back(MCAUSE);
      read_back(MTVAL);
      read_back(MSTATUS);
      if (i % 2 == 0) begin
        issue(encode_system(FUNCT12_MRET), random_pc(), '0);
        read_back(MSTATUS);
      end
      drain();
    end

    // Illegal encodings and unknown CSR addresses
    for (int i = 0; i < 32; i++) begin
      bad = word_t'($random(seed));
      case (i % 4)
        0:       bad[0] = 1'b0;
        1:       bad = encode_csr(bad[31:20], 3'b100, bad[19:15], bad[11:7]);
        2:       bad = encode_system(bad[31:20]);
        default: bad = encode_csr(bad[31:20], 3'b101, bad[19:15], bad[11:7]);
      endcase
      issue(bad, random_pc(), word_t'($random(seed)));
      read_back(MCAUSE);
      read_back(MTVAL);
    end
    drain();

    // mip follows the irq levels
    for (int i = 0; i < 16; i++) begin
      software_irq = 1'($random(seed));
      timer_irq    = 1'($random(seed));
      external_irq = 1'($random(seed));
      idle(2);
      read_back(MIP);
      drain();
    end

    // Long bursts with traps to back-pressure the queue
    for (int b = 0; b < 8; b++) begin
      for (int i = 0; i < 40; i++) begin
        pick = $unsigned($random(seed)) % 10;
        if (pick < 7) begin
          random_csr_op(csr_list[$unsigned($random(seed)) % 9]);
        end else if (pick < 9) begin
          issue(encode_system(pick == 7 ? FUNCT12_ECALL : FUNCT12_EBREAK), random_pc(), '0);
        end else begin
          issue(encode_system(FUNCT12_MRET), random_pc(), '0);
        end
      end
      idle(3);
    end
    read_back(MINSTRET);
    drain();

    if (i_csr_exec_top.i_csr_file.i_csr_exec_checker.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* csr_exec_top.f */
+incdir+bench
hdl/csr_arch_pkg.sv
hdl/csr_pipe_pkg.sv
hdl/sys_decode.sv
hdl/sys_queue.sv
hdl/csr_file.sv
hdl/csr_exec_top.sv
bench/csr_exec_checker.sv
bench/csr_exec_tb.sv
